/* all.f */
+incdir+tests
hdl/isa_pkg.sv
hdl/stream_pkg.sv
hdl/issue_if.sv
hdl/fetch.sv
hdl/decode.sv
hdl/execute.sv
hdl/audio_port.sv
hdl/audio_cpu.sv
tests/tb_audio_cpu.sv

/* Bender.yml */
package:
  name: audio_cpu

sources:
  - files:
      - hdl/isa_pkg.sv
      - hdl/stream_pkg.sv
      - hdl/issue_if.sv
      - hdl/fetch.sv
      - hdl/decode.sv
      - hdl/execute.sv
      - hdl/audio_port.sv
      - hdl/audio_cpu.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/tb_audio_cpu.sv

/* tests/tb_ref_model.svh */
function automatic word_t r_word(input opcode_e op, input int rd, input int rs1, input int rs2);
    instr_u w;
    w               = '0;
    w.r_form.opcode = op;
    w.r_form.rd     = reg_idx_t'(rd);
    w.r_form.rs1    = reg_idx_t'(rs1);
    w.r_form.rs2    = reg_idx_t'(rs2);
    return w;
endfunction

function automatic word_t i_word(input opcode_e op, input int rd, input int rs1, input int imm);
    instr_u w;
    w               = '0;
    w.i_form.opcode = op;
    w.i_form.rd     = reg_idx_t'(rd);
    w.i_form.rs1    = reg_idx_t'(rs1);
    w.i_form.imm    = 16'(imm);
    return w;
endfunction

// Register state carries over between programs, as in the core
function automatic sample_q_t interpret(input word_q_t prog);
    sample_q_t out_q;
    instr_u    w;
    sample_t   a;
    sample_t   b;
    sample_t   imm;
    sample_t   result;
    bit        writes;
    bit        done;
    int        pc;
    int        steps;
    pc    = 0;
    steps = 0;
    done  = 1'b0;
    while (!done && pc < prog.size() && steps < 10000) begin
        w      = prog[pc];
        a      = ref_regs[w.i_form.rs1];
        b      = ref_regs[w.r_form.rs2];
        imm    = sample_t'($signed(w.i_form.imm));
        result = '0;
        writes = 1'b0;
        pc++;
        steps++;
        case (w.r_form.opcode)
            ADD: begin
                result = a + b;
                writes = 1'b1;
            end
            SUB: begin
                result = a - b;
                writes = 1'b1;
            end
            ADDI: begin
                result = a + imm;
                writes = 1'b1;
            end
            SHR: begin
                // One bit at a time, copying the sign bit in
                result = a;
                for (int k = 0; k < int'(imm); k++) begin
                    result = {result[DATAW-1], result[DATAW-1:1]};
                end
                writes = 1'b1;
            end
            OUT: out_q.push_back(a);
            BNZ: begin
                if (a != '0) begin
                    pc = int'(w.i_form.imm);
                end
            end
            HALT: done = 1'b1;
            default: ;
        endcase
        // r0 stays zero
        if (writes && w.r_form.rd != '0) begin
            ref_regs[w.r_form.rd] = result;
        end
    end
    return out_q;
endfunction

// Dependent chain, arithmetic shift of a negative value, wrapping add
function automatic word_q_t chain_program();
    word_q_t p;
    p = {
        i_word(ADDI, 1, 0, 100),
        i_word(ADDI, 2, 1, 23),
        r_word(ADD, 3, 2, 1),
        r_word(SUB, 4, 3, 2),
        i_word(ADDI, 5, 4, -1000),
        i_word(OUT, 0, 5, 0),
        i_word(SHR, 6, 5, 2),
        i_word(OUT, 0, 6, 0),
        i_word(SHR, 6, 5, 15),
        i_word(OUT, 0, 6, 0),
        i_word(ADDI, 7, 0, 30000),
        r_word(ADD, 7, 7, 7),
        i_word(OUT, 0, 7, 0),
        i_word(HALT, 0, 0, 0)
    };
    return p;
endfunction

// Counts down 5..1; words 5 and 6 run only once, on loop exit
function automatic word_q_t countdown_program();
    word_q_t p;
    p = {
        i_word(ADDI, 3, 0, 0),
        i_word(ADDI, 1, 0, 5),
        i_word(OUT, 0, 1, 0),
        i_word(ADDI, 1, 1, -1),
        i_word(BNZ, 0, 1, 2),
        i_word(ADDI, 3, 3, 1),
        i_word(OUT, 0, 3, 0),
        i_word(HALT, 0, 0, 0)
    };
    return p;
endfunction

// Back-to-back OUTs, 24 samples
function automatic word_q_t stream_program();
    word_q_t p;
    p = {
        i_word(ADDI, 1, 0, 12),
        i_word(ADDI, 2, 0, -7),
        i_word(OUT, 0, 1, 0),
        i_word(OUT, 0, 2, 0),
        i_word(ADDI, 2, 2, 3),
        i_word(ADDI, 1, 1, -1),
        i_word(BNZ, 0, 1, 2),
        i_word(HALT, 0, 0, 0)
    };
    return p;
endfunction

function automatic word_q_t halt_program();
    word_q_t p;
    p = {
        i_word(ADDI, 1, 0, 42),
        i_word(OUT, 0, 1, 0),
        i_word(HALT, 0, 0, 0),
        i_word(OUT, 0, 1, 0),
        i_word(ADDI, 1, 1, 1),
        i_word(OUT, 0, 1, 0),
        i_word(HALT, 0, 0, 0)
    };
    return p;
endfunction

// Reads r1 as left behind by the halted program
function automatic word_q_t reload_program();
    word_q_t p;
    p = {
        i_word(OUT, 0, 1, 0),
        i_word(ADDI, 2, 1, -50),
        i_word(SHR, 3, 2, 1),
        i_word(OUT, 0, 3, 0),
        i_word(HALT, 0, 0, 0)
    };
    return p;
endfunction

/* tests/tb_audio_cpu.sv */
module tb_audio_cpu
    import isa_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int DATAW         = 16;
    localparam int IMEM_DEPTH    = 64;
    localparam int AUDIO_CREDITS = 4;
    localparam int WAIT_LIMIT    = 4000;

    typedef logic [DATAW-1:0]   sample_t;
    typedef logic [INSTR_W-1:0] word_t;
    typedef sample_t            sample_q_t[$];
    typedef word_t              word_q_t[$];

    logic    clk;
    logic    arst_n;
    logic    instr_write_en;
    word_t   instr_data;
    logic    start;
    logic    audio_credit;
    logic    audio_valid;
    sample_t audio_data;
    logic    halted;

    integer    seed = 66;
    int        mismatches = 0;
    int        failures = 0;
    int        pulses = 0;
    int        returned = 0;
    bit        throttle = 1'b0;
    bit        timed_out = 1'b0;
    sample_q_t expected_q;
    sample_t   ref_regs [NUM_REGS] = '{default: '0};

    `include "tb_ref_model.svh"

    audio_cpu #(
        .DATAW(DATAW),
        .IMEM_DEPTH(IMEM_DEPTH),
        .AUDIO_CREDITS(AUDIO_CREDITS)
    ) audio_cpu_inst (
        .clk(clk), .arst_n(arst_n),
        .instr_write_en(instr_write_en), .instr_data(instr_data), .start(start),
        .audio_credit(audio_credit),
        .audio_valid(audio_valid), .audio_data(audio_data), .halted(halted)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic check_sample(input string name, input sample_t expected, input sample_t actual);
        if (actual !== expected) begin
            mismatches++;
            $display("Mismatch at %0t: %s expected %0d, got %0d",
                     $time, name, $signed(expected), $signed(actual));
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            mismatches++;
            $display("Mismatch at %0t: %s expected %b, got %b", $time, name, expected, actual);
        end
    endtask

    // Mid-cycle sampling of the audio port
    always @(negedge clk) begin
        if (arst_n === 1'b1) begin
            if (audio_valid === 1'b1) begin
                pulses++;
                if (pulses > AUDIO_CREDITS + returned) begin
                    failures++;
                    $display("At %0t an audio sample was sent without a credit", $time);
                end
                if (expected_q.size() == 0) begin
                    failures++;
                    $display("At %0t an audio sample %0d arrived when none was expected",
                             $time, $signed(audio_data));
                end else begin
                    check_sample("audio_data", expected_q.pop_front(), audio_data);
                end
            end
            if (audio_credit === 1'b1) begin
                returned++;
            end
        end
    end

    // Consumer returns credits only for samples already received
    initial begin : credit_driver
        int owed;
        int hold;
        owed         = 0;
        hold         = 0;
        audio_credit = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            if (audio_credit) begin
                owed--;
            end
            if (audio_valid === 1'b1) begin
                owed++;
            end
            if (hold > 0) begin
                hold--;
            end else if (throttle && ($random(seed) & 3) == 0) begin
                hold = 3 + ($random(seed) & 15);
            end
            audio_credit = owed > 0 && hold == 0;
        end
    end

    task automatic run_program(input string label, input word_q_t prog);
        int cycles;
        if (timed_out) begin
            return;
        end
        expected_q = interpret(prog);
        foreach (prog[i]) begin
            instr_write_en = 1'b1;
            instr_data     = prog[i];
            @(posedge clk);
            #1;
        end
        instr_write_en = 1'b0;
        start          = 1'b1;
        @(posedge clk);
        #1;
        start = 1'b0;
        check_flag("halted", 1'b0, halted);
        cycles = 0;
        while (halted !== 1'b1 && cycles < WAIT_LIMIT) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (halted !== 1'b1) begin
            failures++;
            timed_out = 1'b1;
            $display("Timeout: program %s did not halt within %0d cycles", label, WAIT_LIMIT);
        end else if (expected_q.size() != 0) begin
            failures++;
            $display("Program %s halted with %0d samples never sent", label, expected_q.size());
        end
        // Quiet window after HALT
        repeat (8) begin
            @(posedge clk);
            #1;
        end
        expected_q.delete();
    endtask

    initial begin
        arst_n         = 1'b0;
        instr_write_en = 1'b0;
        instr_data     = '0;
        start          = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        arst_n = 1'b1;
        check_flag("audio_valid", 1'b0, audio_valid);
        check_flag("halted", 1'b0, halted);
        @(posedge clk);
        #1;
        run_program("chain", chain_program());
        run_program("countdown", countdown_program());
        throttle = 1'b1;
        run_program("stream", stream_program());
        throttle = 1'b0;
        run_program("halt", halt_program());
        run_program("reload", reload_program());
        $display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

/* hdl/audio_cpu.sv */
module audio_cpu
    import isa_pkg::*;
    import stream_pkg::*;
#(
    parameter int DATAW         = SAMPLE_W_DEFAULT,
    parameter int IMEM_DEPTH    = 64,
    parameter int AUDIO_CREDITS = 4
) (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               instr_write_en,
    input  logic [INSTR_W-1:0] instr_data,
    input  logic               start,
    input  logic               audio_credit,
    output logic               audio_valid,
    output logic [DATAW-1:0]   audio_data,
    output logic               halted
);
    localparam int PC_W = $clog2(IMEM_DEPTH);

    logic             fetch_valid;
    instr_u           fetch_instr;
    logic [PC_W-1:0]  fetch_pc;
    logic             stall;
    logic             wb_en;
    reg_idx_t         wb_rd;
    logic [DATAW-1:0] wb_data;
    logic             branch_taken;
    logic [DATAW-1:0] branch_target;
    logic             out_req;
    logic             out_ready;
    logic [DATAW-1:0] out_data;

    issue_if #(.DATAW(DATAW)) issue ();

    fetch #(
        .DATAW(DATAW),
        .IMEM_DEPTH(IMEM_DEPTH)
    ) fetch_inst (
        .clk(clk), .arst_n(arst_n),
        .instr_write_en(instr_write_en), .instr_data(instr_data), .start(start),
        .stall(stall), .flush(issue.flush),
        .branch_taken(branch_taken), .branch_target(branch_target), .halted(halted),
        .valid(fetch_valid), .instr(fetch_instr), .pc(fetch_pc)
    );

    decode #(
        .DATAW(DATAW)
    ) decode_inst (
        .clk(clk), .arst_n(arst_n),
        .valid(fetch_valid), .instr(fetch_instr), .stall(stall),
        .wb_en(wb_en), .wb_rd(wb_rd), .wb_data(wb_data),
        .issue(issue)
    );

    execute #(
        .DATAW(DATAW)
    ) execute_inst (
        .clk(clk), .arst_n(arst_n), .start(start), .out_ready(out_ready),
        .issue(issue),
        .wb_en(wb_en), .wb_rd(wb_rd), .wb_data(wb_data),
        .branch_taken(branch_taken), .branch_target(branch_target),
        .out_req(out_req), .out_data(out_data), .stall(stall), .halted(halted)
    );

    audio_port #(
        .DATAW(DATAW),
        .AUDIO_CREDITS(AUDIO_CREDITS)
    ) audio_port_inst (
        .clk(clk), .arst_n(arst_n),
        .out_req(out_req), .out_data(out_data), .audio_credit(audio_credit),
        .out_ready(out_ready), .audio_valid(audio_valid), .audio_data(audio_data)
    );

    // Taken branch reaches decode from its target after two bubbles
    assert property (@(posedge clk) disable iff (!arst_n)
        branch_taken |-> ##2 (fetch_valid && fetch_pc == PC_W'($past(branch_target, 2))))
        else $error("branch target not fetched");

endmodule

/* hdl/audio_port.sv */
module audio_port
    import stream_pkg::*;
#(
    parameter int DATAW         = 16,
    parameter int AUDIO_CREDITS = 4
) (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             out_req,
    input  logic [DATAW-1:0] out_data,
    input  logic             audio_credit,
    output logic             out_ready,
    output logic             audio_valid,
    output logic [DATAW-1:0] audio_data
);
    logic [CREDIT_W-1:0] credits;
    logic                send;

    assign out_ready = credits != '0;
    assign send      = out_req && out_ready;

    // Spend and return can land on the same edge
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            credits     <= CREDIT_W'(AUDIO_CREDITS);
            audio_valid <= 1'b0;
        end else begin
            audio_valid <= send;
            case ({send, audio_credit})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (send) begin
            audio_data <= out_data;
        end
    end

    assert property (@(posedge clk) disable iff (!arst_n) credits <= CREDIT_W'(AUDIO_CREDITS))
        else $error("consumer returned more credits than it was given");

    assert property (@(posedge clk) disable iff (!arst_n) out_req |-> credits != '0)
        else $error("audio request with no credit");

endmodule

/* hdl/execute.sv */
module execute
    import isa_pkg::*;
#(
    parameter int DATAW = 16
) (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             start,
    input  logic             out_ready,
    issue_if.execute         issue,
    output logic             wb_en,
    output reg_idx_t         wb_rd,
    output logic [DATAW-1:0] wb_data,
    output logic             branch_taken,
    output logic [DATAW-1:0] branch_target,
    output logic             out_req,
    output logic [DATAW-1:0] out_data,
    output logic             stall,
    output logic             halted
);
    logic             is_out;
    logic             halt_now;
    logic [DATAW-1:0] alu_result;

    always_comb begin
        case (issue.op)
            ADD:     alu_result = issue.a + issue.b;
            SUB:     alu_result = issue.a - issue.b;
            ADDI:    alu_result = issue.a + issue.imm;
            SHR:     alu_result = $signed(issue.a) >>> issue.imm;
            default: alu_result = issue.a;
        endcase
    end

    assign is_out   = issue.valid && issue.op == OUT;
    assign halt_now = issue.valid && issue.op == HALT;

    // OUT waits here until the audio port holds a credit
    assign stall    = is_out && !out_ready;
    assign out_req  = is_out && out_ready;
    assign out_data = issue.a;

    assign wb_en   = issue.valid && issue.wr_en && !stall;
    assign wb_rd   = issue.rd;
    assign wb_data = alu_result;

    assign branch_taken  = issue.valid && issue.op == BNZ && issue.a != '0;
    assign branch_target = issue.imm;
    assign issue.flush   = branch_taken || halt_now;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            halted <= 1'b0;
        end else if (start) begin
            halted <= 1'b0;
        end else if (halt_now) begin
            halted <= 1'b1;
        end
    end

endmodule

/* hdl/decode.sv */
module decode
    import isa_pkg::*;
#(
    parameter int DATAW = 16
) (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             valid,
    input  instr_u           instr,
    input  logic             stall,
    input  logic             wb_en,
    input  reg_idx_t         wb_rd,
    input  logic [DATAW-1:0] wb_data,
    issue_if.decode          issue
);
    logic [DATAW-1:0] regs [NUM_REGS];
    reg_idx_t         rs1;
    reg_idx_t         rs2;
    logic [DATAW-1:0] imm;
    logic             wr_en;

    // Register read with r0 forced to zero and write-back bypass
    function automatic logic [DATAW-1:0] operand(
        input reg_idx_t         idx,
        input logic [DATAW-1:0] rf_word,
        input logic             byp_en,
        input reg_idx_t         byp_rd,
        input logic [DATAW-1:0] byp_data
    );
        if (idx == '0) begin
            return '0;
        end
        if (byp_en && byp_rd == idx) begin
            return byp_data;
        end
        return rf_word;
    endfunction

    always_comb begin
        rs1   = instr.i_form.rs1;
        rs2   = '0;
        imm   = DATAW'(signed'(instr.i_form.imm));
        wr_en = 1'b0;
        case (instr.r_form.opcode)
            ADD, SUB: begin
                rs2   = instr.r_form.rs2;
                wr_en = 1'b1;
            end
            SHR, ADDI: wr_en = 1'b1;
            default: ;
        endcase
        // Writes to r0 are dropped here
        if (instr.r_form.rd == '0) begin
            wr_en = 1'b0;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en && wb_rd != '0) begin
            regs[wb_rd] <= wb_data;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            issue.valid <= 1'b0;
        end else if (!stall) begin
            issue.valid <= valid && !issue.flush;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            issue.op    <= instr.r_form.opcode;
            issue.rd    <= instr.r_form.rd;
            issue.a     <= operand(rs1, regs[rs1], wb_en, wb_rd, wb_data);
            issue.b     <= operand(rs2, regs[rs2], wb_en, wb_rd, wb_data);
            issue.imm   <= imm;
            issue.wr_en <= wr_en;
        end
    end

    assert property (@(posedge clk) disable iff (!arst_n) wb_en |-> wb_rd != '0)
        else $error("write-back to r0");

endmodule

/* hdl/fetch.sv */
module fetch
    import isa_pkg::*;
#(
    parameter int DATAW      = 16,
    parameter int IMEM_DEPTH = 64
) (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          instr_write_en,
    input  logic [INSTR_W-1:0]            instr_data,
    input  logic                          start,
    input  logic                          stall,
    input  logic                          flush,
    input  logic                          branch_taken,
    input  logic [DATAW-1:0]              branch_target,
    input  logic                          halted,
    output logic                          valid,
    output instr_u                        instr,
    output logic [$clog2(IMEM_DEPTH)-1:0] pc
);
    localparam int PC_W = $clog2(IMEM_DEPTH);

    instr_u          imem [IMEM_DEPTH];
    logic [PC_W-1:0] load_addr;
    logic [PC_W-1:0] fetch_pc;
    logic            running;
    logic            fetching;

    assign fetching = running && !halted;

    always_ff @(posedge clk) begin
        if (instr_write_en) begin
            imem[load_addr] <= instr_data;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            load_addr <= '0;
            running   <= 1'b0;
        end else if (start) begin
            load_addr <= '0;
            running   <= 1'b1;
        end else begin
            if (instr_write_en) begin
                load_addr <= load_addr + 1'b1;
            end
            if (halted) begin
                running <= 1'b0;
            end
        end
    end

    // PC and fetch/decode valid
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            fetch_pc <= '0;
            valid    <= 1'b0;
        end else if (start) begin
            fetch_pc <= '0;
            valid    <= 1'b0;
        end else if (!stall) begin
            if (flush) begin
                valid <= 1'b0;
                if (branch_taken) begin
                    fetch_pc <= branch_target[PC_W-1:0];
                end
            end else begin
                valid <= fetching;
                if (fetching) begin
                    fetch_pc <= fetch_pc + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!stall && !flush) begin
            instr <= imem[fetch_pc];
            pc    <= fetch_pc;
        end
    end

    // Host may only load while the core is idle
    assert property (@(posedge clk) disable iff (!arst_n) running |-> !instr_write_en)
        else $error("instruction write while the core is running");

endmodule

/* hdl/issue_if.sv */
interface issue_if
    import isa_pkg::*;
#(
    parameter int DATAW = 16
);

    logic             valid;
    opcode_e          op;
    reg_idx_t         rd;
    logic [DATAW-1:0] a;
    logic [DATAW-1:0] b;
    logic [DATAW-1:0] imm;
    logic             wr_en;
    logic             flush;

    modport decode (
        output valid, op, rd, a, b, imm, wr_en,
        input  flush
    );

    modport execute (
        input  valid, op, rd, a, b, imm, wr_en,
        output flush
    );

endinterface

/* hdl/stream_pkg.sv */
package stream_pkg;

    // Audio samples are signed 16-bit unless the top level overrides it
    localparam int SAMPLE_W_DEFAULT = 16;

    // Enough for up to 15 outstanding credits
    localparam int CREDIT_W = 4;

endpackage

/* hdl/isa_pkg.sv */
package isa_pkg;

    localparam int INSTR_W  = 32;
    localparam int NUM_REGS = 8;

    typedef logic [2:0] reg_idx_t;

    typedef enum logic [5:0] {
        NOP  = 6'h00,
        ADD  = 6'h01,
        SUB  = 6'h02,
        SHR  = 6'h03,
        ADDI = 6'h04,
        OUT  = 6'h05,
        BNZ  = 6'h06,
        HALT = 6'h07
    } opcode_e;

    // ADD and SUB
    typedef struct packed {
        opcode_e     opcode;
        reg_idx_t    rd;
        reg_idx_t    rs1;
        reg_idx_t    rs2;
        logic [16:0] pad;
    } r_form_t;

    // ADDI, SHR, OUT, BNZ
    typedef struct packed {
        opcode_e     opcode;
        reg_idx_t    rd;
        reg_idx_t    rs1;
        logic [3:0]  pad;
        logic [15:0] imm;
    } i_form_t;

    typedef union packed {
        r_form_t r_form;
        i_form_t i_form;
    } instr_u;

endpackage
